// File: Bender.yml
package:
  name: game_display

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gamePkg.sv
      - hdl/playerController.sv
      - hdl/drawSequencer.sv
      - hdl/objectSelect.sv
      - hdl/spriteRaster.sv
      - hdl/gameDisplay.sv
  - target: test
    include_dirs:
      - hdl
      - test
    files:
      - test/gameDisplayTb.sv

// File: files.f
+incdir+hdl
+incdir+test
hdl/gamePkg.sv
hdl/playerController.sv
hdl/drawSequencer.sv
hdl/objectSelect.sv
hdl/spriteRaster.sv
hdl/gameDisplay.sv
test/gameDisplayTb.sv

// File: hdl/drawSequencer.sv
`timescale 1ns/1ps

module drawSequencer (
    input  logic                clk,
    input  logic                reset,       // sync, active low
    input  logic                rasterDone,  // rasteriser finished the object
    output logic                frameStart,  // one cycle at the top of each frame
    output logic                loadObject,  // rasteriser latches the object
    output gamePkg::objectSel_t objectSel    // object now being drawn
);

    typedef enum logic [1:0] {
        SEQ_IDLE,    // held in reset, leaves after one cycle
        SEQ_FRAME,   // frame start, moves and enemies get sampled
        SEQ_LOAD,    // hand the selected object to the rasteriser
        SEQ_WAIT     // wait for the rasteriser's done pulse
    } seqState_t;

    seqState_t           state;
    seqState_t           stateNext;
    gamePkg::objectSel_t selNext;

    always_comb begin
        stateNext = state;
        selNext   = objectSel;
        case (state)
            SEQ_IDLE: begin
                stateNext = SEQ_FRAME;                  // first frame right after reset
            end
            SEQ_FRAME: begin
                stateNext = SEQ_LOAD;
                selNext   = gamePkg::OBJ_ERASE;         // every frame opens with the erase
            end
            SEQ_LOAD: begin
                stateNext = SEQ_WAIT;                   // load is a single cycle
            end
            SEQ_WAIT: begin
                if (rasterDone) begin
                    if (objectSel == gamePkg::OBJ_ENEMY3) begin
                        stateNext = SEQ_FRAME;          // list done, wrap around
                    end else begin
                        stateNext = SEQ_LOAD;
                        selNext   = gamePkg::objectSel_t'(objectSel + 3'd1);
                    end
                end
            end
            default: begin
                stateNext = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= SEQ_IDLE;
            objectSel <= gamePkg::OBJ_ERASE;
        end else begin
            state     <= stateNext;
            objectSel <= selNext;
        end
    end

    // strobes decode straight from the state
    assign frameStart = (state == SEQ_FRAME);
    assign loadObject = (state == SEQ_LOAD);

endmodule

// File: hdl/gameDisplay.sv
`timescale 1ns/1ps

module gameDisplay (
    input  logic                 clk,
    input  logic                 reset,        // sync, active low
    input  logic                 moveValid,    // move request in
    input  logic                 moveLeft,
    input  logic                 moveRight,
    output logic                 moveReady,
    input  gamePkg::xCoord_t     enemyX0,
    input  gamePkg::xCoord_t     enemyX1,
    input  gamePkg::xCoord_t     enemyX2,
    input  gamePkg::xCoord_t     enemyX3,
    input  gamePkg::yCoord_t     enemyY0,
    input  gamePkg::yCoord_t     enemyY1,
    input  gamePkg::yCoord_t     enemyY2,
    input  gamePkg::yCoord_t     enemyY3,
    input  gamePkg::spriteSize_t playerWidth,
    input  gamePkg::spriteSize_t playerHeight,
    input  gamePkg::spriteSize_t enemyWidth,
    input  gamePkg::spriteSize_t enemyHeight,
    input  gamePkg::colour_t     enemyColour0,
    input  gamePkg::colour_t     enemyColour1,
    input  gamePkg::colour_t     enemyColour2,
    input  gamePkg::colour_t     enemyColour3,
    input  logic                 pixelReady,   // pixel stream out
    output logic                 pixelValid,
    output gamePkg::xCoord_t     pixelX,
    output gamePkg::yCoord_t     pixelY,
    output gamePkg::colour_t     pixelColour
);

    logic                 frameStart;   // sequencer to player and snapshot
    logic                 loadObject;   // sequencer to rasteriser
    logic                 rasterDone;   // rasteriser back to sequencer
    gamePkg::objectSel_t  objectSel;
    gamePkg::xCoord_t     playerX;
    gamePkg::xCoord_t     eraseX;
    gamePkg::xCoord_t     originX;      // selected rectangle
    gamePkg::yCoord_t     originY;
    gamePkg::spriteSize_t objWidth;
    gamePkg::spriteSize_t objHeight;
    gamePkg::colour_t     objColour;

    playerController uPlayer (
        .clk(clk), .reset(reset), .moveValid(moveValid), .moveLeft(moveLeft),
        .moveRight(moveRight), .frameStart(frameStart), .moveReady(moveReady),
        .playerX(playerX), .eraseX(eraseX)
    );

    drawSequencer uSequencer (
        .clk(clk), .reset(reset), .rasterDone(rasterDone),
        .frameStart(frameStart), .loadObject(loadObject), .objectSel(objectSel)
    );

    objectSelect uSelect (
        .clk(clk), .reset(reset), .frameStart(frameStart), .objectSel(objectSel),
        .playerX(playerX), .eraseX(eraseX),
        .enemyX0(enemyX0), .enemyX1(enemyX1), .enemyX2(enemyX2), .enemyX3(enemyX3),
        .enemyY0(enemyY0), .enemyY1(enemyY1), .enemyY2(enemyY2), .enemyY3(enemyY3),
        .playerWidth(playerWidth), .playerHeight(playerHeight),
        .enemyWidth(enemyWidth), .enemyHeight(enemyHeight),
        .enemyColour0(enemyColour0), .enemyColour1(enemyColour1),
        .enemyColour2(enemyColour2), .enemyColour3(enemyColour3),
        .originX(originX), .originY(originY), .objWidth(objWidth),
        .objHeight(objHeight), .objColour(objColour)
    );

    spriteRaster uRaster (
        .clk(clk), .reset(reset), .loadObject(loadObject),
        .originX(originX), .originY(originY), .objWidth(objWidth),
        .objHeight(objHeight), .objColour(objColour), .pixelReady(pixelReady),
        .pixelValid(pixelValid), .pixelX(pixelX), .pixelY(pixelY),
        .pixelColour(pixelColour), .rasterDone(rasterDone)
    );

endmodule

// File: hdl/gamePkg.sv
`include "game_config.svh"

package gamePkg;

    typedef logic [`X_WIDTH-1:0]      xCoord_t;     // pixel column
    typedef logic [`Y_WIDTH-1:0]      yCoord_t;     // pixel row
    typedef logic [`SIZE_WIDTH-1:0]   spriteSize_t; // sprite width or height
    typedef logic [`COLOUR_WIDTH-1:0] colour_t;     // 3-bit rgb
    typedef logic [1:0]               lane_t;       // one of NUM_LANES lanes

    // draw order within one frame, the sequencer steps through these in turn
    typedef enum logic [2:0] {
        OBJ_ERASE,   // black box over the old player position
        OBJ_PLAYER,  // player at its current lane
        OBJ_ENEMY0,
        OBJ_ENEMY1,
        OBJ_ENEMY2,
        OBJ_ENEMY3   // last object of the frame
    } objectSel_t;

endpackage

// File: hdl/game_config.svh
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// field widths
`define X_WIDTH       8     // screen x, 0..159 plus off-screen margin
`define Y_WIDTH       7     // screen y, 0..119
`define SIZE_WIDTH    5     // sprite width and height, up to 31
`define COLOUR_WIDTH  3     // rgb, one bit each

// object counts
`define NUM_ENEMIES   4
`define NUM_LANES     4

// lane geometry, lanes sit at x of 14, 54, 94, 134
`define LANE0_X       14
`define LANE_STEP     40
`define PLAYER_Y      99    // player row never changes

// fixed colours
`define PLAYER_COLOUR 7     // white
`define ERASE_COLOUR  0     // black

// objects with origin x at or past this are not drawn
`define X_LIMIT       180

`endif

// File: hdl/objectSelect.sv
`timescale 1ns/1ps
`include "game_config.svh"

module objectSelect (
    input  logic                  clk,
    input  logic                  reset,        // sync, active low
    input  logic                  frameStart,   // snapshot strobe
    input  gamePkg::objectSel_t   objectSel,    // object the sequencer wants
    input  gamePkg::xCoord_t      playerX,
    input  gamePkg::xCoord_t      eraseX,
    input  gamePkg::xCoord_t      enemyX0,
    input  gamePkg::xCoord_t      enemyX1,
    input  gamePkg::xCoord_t      enemyX2,
    input  gamePkg::xCoord_t      enemyX3,
    input  gamePkg::yCoord_t      enemyY0,
    input  gamePkg::yCoord_t      enemyY1,
    input  gamePkg::yCoord_t      enemyY2,
    input  gamePkg::yCoord_t      enemyY3,
    input  gamePkg::spriteSize_t  playerWidth,
    input  gamePkg::spriteSize_t  playerHeight,
    input  gamePkg::spriteSize_t  enemyWidth,   // shared by all enemies
    input  gamePkg::spriteSize_t  enemyHeight,
    input  gamePkg::colour_t      enemyColour0,
    input  gamePkg::colour_t      enemyColour1,
    input  gamePkg::colour_t      enemyColour2,
    input  gamePkg::colour_t      enemyColour3,
    output gamePkg::xCoord_t      originX,      // rectangle of the selected object
    output gamePkg::yCoord_t      originY,
    output gamePkg::spriteSize_t  objWidth,
    output gamePkg::spriteSize_t  objHeight,
    output gamePkg::colour_t      objColour
);

    gamePkg::xCoord_t     enemyXIn [`NUM_ENEMIES];  // loose ports gathered up
    gamePkg::yCoord_t     enemyYIn [`NUM_ENEMIES];
    gamePkg::colour_t     enemyCIn [`NUM_ENEMIES];
    gamePkg::xCoord_t     enemyXReg [`NUM_ENEMIES]; // frame snapshot
    gamePkg::yCoord_t     enemyYReg [`NUM_ENEMIES];
    gamePkg::colour_t     enemyCReg [`NUM_ENEMIES];
    gamePkg::spriteSize_t playerWReg;
    gamePkg::spriteSize_t playerHReg;
    gamePkg::spriteSize_t enemyWReg;
    gamePkg::spriteSize_t enemyHReg;
    logic [1:0]           enemyOffset;              // objectSel relative to enemy 0

    assign enemyXIn = '{enemyX0, enemyX1, enemyX2, enemyX3};
    assign enemyYIn = '{enemyY0, enemyY1, enemyY2, enemyY3};
    assign enemyCIn = '{enemyColour0, enemyColour1, enemyColour2, enemyColour3};

    // inputs may change mid-frame, only the frame-start values count
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < `NUM_ENEMIES; i++) begin
                enemyXReg[i] <= '0;
                enemyYReg[i] <= '0;
                enemyCReg[i] <= '0;
            end
            playerWReg <= '0;
            playerHReg <= '0;
            enemyWReg  <= '0;
            enemyHReg  <= '0;
        end else if (frameStart) begin
            for (int i = 0; i < `NUM_ENEMIES; i++) begin
                enemyXReg[i] <= enemyXIn[i];
                enemyYReg[i] <= enemyYIn[i];
                enemyCReg[i] <= enemyCIn[i];
            end
            playerWReg <= playerWidth;
            playerHReg <= playerHeight;
            enemyWReg  <= enemyWidth;
            enemyHReg  <= enemyHeight;
        end
    end

    assign enemyOffset = 2'(objectSel - gamePkg::OBJ_ENEMY0);

    always_comb begin
        case (objectSel)
            gamePkg::OBJ_ERASE: begin            // player-sized black box at old lane
                originX   = eraseX;
                originY   = gamePkg::yCoord_t'(`PLAYER_Y);
                objWidth  = playerWReg;
                objHeight = playerHReg;
                objColour = gamePkg::colour_t'(`ERASE_COLOUR);
            end
            gamePkg::OBJ_PLAYER: begin
                originX   = playerX;
                originY   = gamePkg::yCoord_t'(`PLAYER_Y);
                objWidth  = playerWReg;
                objHeight = playerHReg;
                objColour = gamePkg::colour_t'(`PLAYER_COLOUR);
            end
            default: begin                       // one of the enemies
                originX   = enemyXReg[enemyOffset];
                originY   = enemyYReg[enemyOffset];
                objWidth  = enemyWReg;
                objHeight = enemyHReg;
                objColour = enemyCReg[enemyOffset];
            end
        endcase
    end

endmodule

// File: hdl/playerController.sv
`timescale 1ns/1ps
`include "game_config.svh"

module playerController (
    input  logic             clk,
    input  logic             reset,        // sync, active low
    input  logic             moveValid,    // a move request is offered
    input  logic             moveLeft,     // step one lane left
    input  logic             moveRight,    // step one lane right, wins over left
    input  logic             frameStart,   // one cycle per frame from the sequencer
    output logic             moveReady,    // request taken only at frame start
    output gamePkg::xCoord_t playerX,      // x of the player this frame
    output gamePkg::xCoord_t eraseX        // x of last frame's player, to blank
);

    gamePkg::lane_t lane;                  // current lane
    gamePkg::lane_t eraseLane;             // lane drawn in the previous frame
    gamePkg::lane_t laneNext;              // lane after applying the request

    // lane index to left edge x
    function automatic gamePkg::xCoord_t laneToX(input gamePkg::lane_t laneIn);
        int xValue;
        xValue = `LANE0_X + int'(laneIn) * `LANE_STEP;
        return gamePkg::xCoord_t'(xValue);
    endfunction

    assign moveReady = frameStart;         // one request per frame

    // right has priority, both ends clamp
    always_comb begin
        laneNext = lane;
        if (moveRight) begin
            if (lane != gamePkg::lane_t'(`NUM_LANES - 1)) begin
                laneNext = lane + 1'b1;
            end
        end else if (moveLeft) begin
            if (lane != '0) begin
                laneNext = lane - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            lane      <= '0;               // start at the leftmost lane
            eraseLane <= '0;
        end else if (frameStart) begin
            eraseLane <= lane;             // old lane gets blanked this frame
            if (moveValid) begin
                lane <= laneNext;          // handshake done, take the move
            end
        end
    end

    assign playerX = laneToX(lane);
    assign eraseX  = laneToX(eraseLane);

endmodule

// File: hdl/spriteRaster.sv
`timescale 1ns/1ps
`include "game_config.svh"

module spriteRaster (
    input  logic                 clk,
    input  logic                 reset,        // sync, active low
    input  logic                 loadObject,   // latch a new rectangle
    input  gamePkg::xCoord_t     originX,      // top-left corner
    input  gamePkg::yCoord_t     originY,
    input  gamePkg::spriteSize_t objWidth,
    input  gamePkg::spriteSize_t objHeight,
    input  gamePkg::colour_t     objColour,
    input  logic                 pixelReady,   // frame-buffer writer can take a pixel
    output logic                 pixelValid,
    output gamePkg::xCoord_t     pixelX,
    output gamePkg::yCoord_t     pixelY,
    output gamePkg::colour_t     pixelColour,
    output logic                 rasterDone    // one-cycle pulse per object
);

    typedef enum logic [1:0] {
        RAS_IDLE,   // waiting for a load
        RAS_DRAW,   // streaming pixels
        RAS_DONE    // done pulse
    } rasState_t;

    rasState_t            state;
    gamePkg::xCoord_t     baseX;          // latched rectangle
    gamePkg::yCoord_t     baseY;
    gamePkg::spriteSize_t width;
    gamePkg::spriteSize_t height;
    gamePkg::colour_t     colourReg;
    gamePkg::spriteSize_t colCount;       // offset within the row
    gamePkg::spriteSize_t rowCount;       // offset within the object
    logic                 skipObj;
    logic                 transfer;
    logic                 lastCol;
    logic                 lastRow;

    // off the right edge or empty, nothing to draw
    assign skipObj = (originX >= `X_LIMIT) || (objWidth == '0) || (objHeight == '0);

    assign transfer = pixelValid && pixelReady;
    assign lastCol  = (colCount == width - 1'b1);
    assign lastRow  = (rowCount == height - 1'b1);

    always_ff @(posedge clk) begin
        if (loadObject) begin
            baseX     <= originX;
            baseY     <= originY;
            width     <= objWidth;
            height    <= objHeight;
            colourReg <= objColour;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= RAS_IDLE;
            colCount <= '0;
            rowCount <= '0;
        end else begin
            case (state)
                RAS_IDLE: begin
                    if (loadObject) begin
                        colCount <= '0;
                        rowCount <= '0;
                        state    <= skipObj ? RAS_DONE : RAS_DRAW;  // skip goes straight to done
                    end
                end
                RAS_DRAW: begin
                    if (transfer) begin                 // counters only move on a transfer
                        if (lastCol) begin
                            colCount <= '0;
                            if (lastRow) begin
                                state <= RAS_DONE;      // that was the last pixel
                            end else begin
                                rowCount <= rowCount + 1'b1;
                            end
                        end else begin
                            colCount <= colCount + 1'b1;
                        end
                    end
                end
                RAS_DONE: begin
                    state <= RAS_IDLE;
                end
                default: begin
                    state <= RAS_IDLE;
                end
            endcase
        end
    end

    // coordinates wrap at the field width, stable while stalled
    assign pixelValid  = (state == RAS_DRAW);
    assign pixelX      = baseX + gamePkg::xCoord_t'(colCount);
    assign pixelY      = baseY + gamePkg::yCoord_t'(rowCount);
    assign pixelColour = colourReg;
    assign rasterDone  = (state == RAS_DONE);

endmodule

// File: test/pixelModel.svh
`ifndef PIXEL_MODEL_SVH
`define PIXEL_MODEL_SVH

gamePkg::lane_t   modelLane;        // lane the player is drawn at this frame
gamePkg::lane_t   modelEraseLane;   // lane that gets blanked this frame
gamePkg::xCoord_t expX [$];         // expected pixel stream, front is next
gamePkg::yCoord_t expY [$];
gamePkg::colour_t expC [$];

// one step per frame, right beats left, stops at the outer lanes
function automatic gamePkg::lane_t predictLane(input gamePkg::lane_t current,
                                               input logic left, input logic right);
    int target;
    target = int'(current);
    if (right) begin
        target = target + 1;
    end else if (left) begin
        target = target - 1;
    end
    if (target < 0) target = 0;
    if (target > `NUM_LANES - 1) target = `NUM_LANES - 1;
    return gamePkg::lane_t'(target);
endfunction

function automatic gamePkg::xCoord_t laneLeftEdge(input gamePkg::lane_t lane);
    return gamePkg::xCoord_t'(`LANE0_X + `LANE_STEP * int'(lane));
endfunction

// row-major pixels of one rectangle, coordinates wrap at the field width
task automatic queueRect(input gamePkg::xCoord_t x, input gamePkg::yCoord_t y,
                         input gamePkg::spriteSize_t w, input gamePkg::spriteSize_t h,
                         input gamePkg::colour_t c);
    if (int'(x) < `X_LIMIT && w != 0 && h != 0) begin   // otherwise nothing is drawn
        for (int row = 0; row < int'(h); row++) begin
            for (int col = 0; col < int'(w); col++) begin
                expX.push_back(gamePkg::xCoord_t'(int'(x) + col));
                expY.push_back(gamePkg::yCoord_t'(int'(y) + row));
                expC.push_back(c);
            end
        end
    end
endtask

// erase at the old lane, then the player at the new one
task automatic modelPlayer(input logic left, input logic right,
                           input gamePkg::spriteSize_t w, input gamePkg::spriteSize_t h);
    modelEraseLane = modelLane;
    modelLane      = predictLane(modelLane, left, right);
    queueRect(laneLeftEdge(modelEraseLane), gamePkg::yCoord_t'(`PLAYER_Y), w, h,
              gamePkg::colour_t'(`ERASE_COLOUR));
    queueRect(laneLeftEdge(modelLane), gamePkg::yCoord_t'(`PLAYER_Y), w, h,
              gamePkg::colour_t'(`PLAYER_COLOUR));
endtask

task automatic clearExpected();
    expX.delete();
    expY.delete();
    expC.delete();
endtask

`endif

// File: test/gameDisplayTb.sv
`timescale 1ns/1ps
`include "game_config.svh"

module gameDisplayTb;

    localparam logic [31:0] Seed = 32'h798d_71f8;
    localparam int TotalFrames   = 47;                       // frames over all five tests
    localparam int TimeoutCycles = TotalFrames * 6 * (31 * 31 + 2) * 4;

    logic                 clk;
    logic                 reset;
    logic                 moveValid;
    logic                 moveLeft;
    logic                 moveRight;
    logic                 moveReady;
    gamePkg::xCoord_t     enemyX [`NUM_ENEMIES];             // split onto the loose ports
    gamePkg::yCoord_t     enemyY [`NUM_ENEMIES];
    gamePkg::colour_t     enemyColour [`NUM_ENEMIES];
    gamePkg::spriteSize_t playerWidth;
    gamePkg::spriteSize_t playerHeight;
    gamePkg::spriteSize_t enemyWidth;
    gamePkg::spriteSize_t enemyHeight;
    logic                 pixelReady;
    logic                 pixelValid;
    gamePkg::xCoord_t     pixelX;
    gamePkg::yCoord_t     pixelY;
    gamePkg::colour_t     pixelColour;

    logic [31:0]          lfsr;
    int                   cycleCount;
    int                   errorCount;
    int                   checkCount;
    int                   failingTests;
    int                   testErrorStart;                    // errors before the running test
    int                   frameIdx;                          // frames started so far
    logic                 newFrame;
    logic                 runDone;
    logic                 stallSeen;                         // valid high, ready low last cycle
    gamePkg::xCoord_t     heldX;
    gamePkg::yCoord_t     heldY;
    gamePkg::colour_t     heldColour;

    `include "pixelModel.svh"

    gameDisplay u_dut (
        .clk(clk), .reset(reset), .moveValid(moveValid), .moveLeft(moveLeft),
        .moveRight(moveRight), .moveReady(moveReady),
        .enemyX0(enemyX[0]), .enemyX1(enemyX[1]), .enemyX2(enemyX[2]), .enemyX3(enemyX[3]),
        .enemyY0(enemyY[0]), .enemyY1(enemyY[1]), .enemyY2(enemyY[2]), .enemyY3(enemyY[3]),
        .playerWidth(playerWidth), .playerHeight(playerHeight),
        .enemyWidth(enemyWidth), .enemyHeight(enemyHeight),
        .enemyColour0(enemyColour[0]), .enemyColour1(enemyColour[1]),
        .enemyColour2(enemyColour[2]), .enemyColour3(enemyColour[3]),
        .pixelReady(pixelReady), .pixelValid(pixelValid), .pixelX(pixelX),
        .pixelY(pixelY), .pixelColour(pixelColour)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                              // 20 ns period
    end

    // galois shift, one step per bit handed out
    function automatic logic [31:0] randomBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic int testOfFrame(input int frame);
        if (frame < 1) return 0;
        if (frame < 21) return 1;
        if (frame < 31) return 2;
        if (frame < 39) return 3;
        if (frame < TotalFrames) return 4;
        return 5;                                            // past the last frame
    endfunction

    function automatic string testName(input int test);
        case (test)
            0: return "first frame after reset";
            1: return "random moves";
            2: return "random back-pressure";
            3: return "skipped objects";
            default: return "enemy updates";
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("error %s: got 0x%0h, expected 0x%0h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic reportFailure(input string what);
        errorCount++;
        $display("%s at %0t", what, $time);
    endtask

    // keys and enemies for one frame, set in the cycle after the previous handshake
    task automatic applyFrameInputs(input int frame);
        int test;
        test = testOfFrame(frame);
        moveLeft  = (test == 0) ? 1'b0 : (randomBits(1) != 0);
        moveRight = (test == 0) ? 1'b0 : (randomBits(1) != 0);
        for (int i = 0; i < `NUM_ENEMIES; i++) begin
            if (test < 3) begin                              // fixed layout, all on screen
                enemyX[i]      = gamePkg::xCoord_t'(20 + 35 * i);
                enemyY[i]      = gamePkg::yCoord_t'(8 + 22 * i);
                enemyColour[i] = gamePkg::colour_t'(i + 1);
            end else begin
                enemyX[i]      = gamePkg::xCoord_t'(randomBits(8));
                enemyY[i]      = gamePkg::yCoord_t'(randomBits(7));
                enemyColour[i] = gamePkg::colour_t'(randomBits(3));
            end
        end
        if (test < 3) begin
            enemyWidth  = 5'd6;
            enemyHeight = 5'd5;
        end else if (test == 3) begin
            enemyX[1]   = gamePkg::xCoord_t'(`X_LIMIT + randomBits(6));  // always off the edge
            enemyWidth  = frame[0] ? gamePkg::spriteSize_t'(randomBits(3)) : '0;
            enemyHeight = gamePkg::spriteSize_t'(randomBits(3));         // zero now and then
        end else begin
            enemyWidth   = gamePkg::spriteSize_t'(randomBits(5));
            enemyHeight  = gamePkg::spriteSize_t'(randomBits(5));
            playerWidth  = gamePkg::spriteSize_t'(randomBits(5));       // player box varies too
            playerHeight = gamePkg::spriteSize_t'(randomBits(5));
        end
    endtask

    // one sample per cycle at the falling edge, where outputs are settled
    task automatic checkPixelCycle();
        if (stallSeen && (!pixelValid || pixelX !== heldX || pixelY !== heldY ||
                          pixelColour !== heldColour)) begin
            reportFailure("pixel outputs changed while the writer was stalling them");
        end
        if (pixelValid && pixelReady) begin
            if (expX.size() == 0) begin
                reportFailure("a pixel was sent when the frame had no pixel left");
            end else begin
                compareValue("pixelX", 32'(pixelX), 32'(expX.pop_front()));
                compareValue("pixelY", 32'(pixelY), 32'(expY.pop_front()));
                compareValue("pixelColour", 32'(pixelColour), 32'(expC.pop_front()));
            end
        end
        stallSeen  = pixelValid && !pixelReady;
        heldX      = pixelX;
        heldY      = pixelY;
        heldColour = pixelColour;
    endtask

    task automatic finishFrame(input int frame);
        int test;
        int errs;
        test = testOfFrame(frame);
        if (expX.size() != 0) begin
            reportFailure($sformatf("frame %0d ended with %0d pixels never sent",
                                    frame, expX.size()));
            clearExpected();
        end
        if (testOfFrame(frame + 1) != test) begin            // last frame of this test
            errs = errorCount - testErrorStart;
            if (errs != 0) failingTests++;
            $display("test %0d %s: %s, %0d errors", test + 1, testName(test),
                     (errs == 0) ? "ok" : "failing", errs);
            testErrorStart = errorCount;
        end
    endtask

    initial begin
        cycleCount = 0;
        while (cycleCount < TimeoutCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout: frames still running after %0d cycles", cycleCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        lfsr           = Seed;
        reset          = 1'b0;
        moveValid      = 1'b1;                               // a request is always on offer
        pixelReady     = 1'b1;
        playerWidth    = 5'd10;
        playerHeight   = 5'd8;
        modelLane      = '0;
        modelEraseLane = '0;
        errorCount     = 0;
        checkCount     = 0;
        failingTests   = 0;
        testErrorStart = 0;
        frameIdx       = 0;
        newFrame       = 1'b0;
        runDone        = 1'b0;
        stallSeen      = 1'b0;
        applyFrameInputs(0);
        repeat (7) begin
            @(negedge clk);
            compareValue("pixelValid", 32'(pixelValid), 32'd0);   // quiet during reset
            compareValue("moveReady", 32'(moveReady), 32'd0);
        end
        @(posedge clk);
        #1 reset = 1'b1;
        while (!runDone) begin
            @(negedge clk);
            checkPixelCycle();
            if (moveValid && moveReady) begin                // frame boundary
                if (frameIdx > 0) finishFrame(frameIdx - 1);
                if (frameIdx == TotalFrames) begin
                    runDone = 1'b1;
                end else begin
                    modelPlayer(moveLeft, moveRight, playerWidth, playerHeight);
                    for (int i = 0; i < `NUM_ENEMIES; i++) begin
                        queueRect(enemyX[i], enemyY[i], enemyWidth, enemyHeight, enemyColour[i]);
                    end
                    frameIdx++;
                    newFrame = 1'b1;
                end
            end
            if (!runDone) begin
                @(posedge clk);
                #1;
                if (newFrame) applyFrameInputs(frameIdx);    // captured at the next frame start
                newFrame   = 1'b0;
                pixelReady = (testOfFrame(frameIdx - 1) == 2) ? (randomBits(1) != 0) : 1'b1;
            end
        end
        $display("summary: 5 tests, %0d failing, %0d checks, %0d errors",
                 failingTests, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
